// ==== hdl/sci_pkg.sv ====
`default_nettype none

package sci_pkg;

	typedef logic [7:0] sci_addr_t;
	typedef logic [7:0] sci_data_t;
	typedef logic [2:0] sci_reg_t;

	// Plain strobe bus, channel in addr[7:3], register in addr[2:0]
	typedef struct packed {
		logic      req;
		logic      we;
		sci_addr_t addr;
		sci_data_t wdata;
	} sci_bus_t;

	typedef struct packed {
		logic eri;
		logic rxi;
		logic txi;
		logic tei;
	} sci_irq_t;

	// One-cycle enables from the prescaler
	typedef struct packed {
		logic ce4;
		logic ce16;
		logic ce64;
		logic ce256;
	} sci_ce_t;

	// Register offsets, 6 and 7 read as zero
	localparam sci_reg_t REG_SMR = 3'd0;
	localparam sci_reg_t REG_BRR = 3'd1;
	localparam sci_reg_t REG_SCR = 3'd2;
	localparam sci_reg_t REG_TDR = 3'd3;
	localparam sci_reg_t REG_SSR = 3'd4;
	localparam sci_reg_t REG_RDR = 3'd5;

	// SCR bits
	localparam int SCR_TIE  = 7;
	localparam int SCR_RIE  = 6;
	localparam int SCR_TE   = 5;
	localparam int SCR_RE   = 4;
	localparam int SCR_TEIE = 2;

	// SSR bits
	localparam int SSR_TDRE = 7;
	localparam int SSR_RDRF = 6;
	localparam int SSR_ORER = 5;
	localparam int SSR_FER  = 4;
	localparam int SSR_TEND = 2;

	localparam sci_data_t SSR_RESET = 8'h84;

	localparam int OVERSAMPLE = 16;

	// Interrupt causes per channel and their index in the vector
	localparam int IRQ_CAUSES = 4;
	localparam int CAUSE_ERI  = 0;
	localparam int CAUSE_RXI  = 1;
	localparam int CAUSE_TXI  = 2;
	localparam int CAUSE_TEI  = 3;

endpackage

`default_nettype wire

// ==== hdl/sci_prescaler.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_prescaler (
	input  wire logic       CLK,
	input  wire logic       RST_N,
	output sci_pkg::sci_ce_t ce
);

	logic [7:0] div_cnt;

	// Strobes fire when the low bits of the counter are all ones
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			ce      <= '0;
		end else begin
			div_cnt  <= div_cnt + 8'd1;
			ce.ce4   <= &div_cnt[1:0];
			ce.ce16  <= &div_cnt[3:0];
			ce.ce64  <= &div_cnt[5:0];
			ce.ce256 <= &div_cnt[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sci_bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_bus_decode #(
	parameter  int NUM_CH = 2,
	localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
	input  wire logic               CLK,
	input  wire logic               RST_N,
	input  wire sci_pkg::sci_bus_t  bus,
	output logic [NUM_CH-1:0]       sel,
	output logic                    we,
	output sci_pkg::sci_reg_t       offset,
	output sci_pkg::sci_data_t      wdata,
	output logic [CH_W-1:0]         rd_ch,
	output logic                    rd_hit
);
	import sci_pkg::*;

	logic [4:0] ch_field;
	logic       in_range;
	logic       rd_req;
	sci_reg_t   rd_off;

	assign ch_field = bus.addr[7:3];
	assign in_range = ch_field < NUM_CH;
	assign rd_req   = bus.req && !bus.we;

	always_comb begin
		sel = '0;
		for (int i = 0; i < NUM_CH; i++) begin
			sel[i] = bus.req && (ch_field == 5'(i));
		end
	end

	// Between accesses the channels keep showing the last read target
	assign offset = bus.req ? bus.addr[2:0] : rd_off;
	assign we     = bus.req && bus.we;
	assign wdata  = bus.wdata;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd_ch  <= '0;
			rd_hit <= 1'b0;
			rd_off <= '0;
		end else if (rd_req) begin
			rd_ch  <= ch_field[CH_W-1:0];
			rd_hit <= in_range;
			rd_off <= bus.addr[2:0];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sci_channel.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_channel (
	input  wire logic               CLK,
	input  wire logic               RST_N,
	input  wire logic               sel,
	input  wire logic               we,
	input  wire sci_pkg::sci_reg_t  offset,
	input  wire sci_pkg::sci_data_t wdata,
	input  wire sci_pkg::sci_ce_t   ce,
	input  wire logic               rxd,
	output logic                    txd,
	output sci_pkg::sci_data_t      rd_byte,
	output sci_pkg::sci_irq_t       irq
);
	import sci_pkg::*;

	localparam int TW = $clog2(OVERSAMPLE);

	logic [1:0] cks;
	sci_data_t  brr;
	sci_data_t  scr;
	sci_data_t  tdr;
	sci_data_t  rdr;
	sci_data_t  ssr;
	logic       tdre, rdrf, orer, fer, tend;
	logic       te, re, wr, wr_tdr, wr_ssr;

	logic       ce_sel, tick;
	sci_data_t  brr_cnt;

	logic          tx_busy, tx_line, tx_adv, tx_end, tx_load, tx_done;
	logic [3:0]    tx_bit;
	logic [TW-1:0] tx_tcnt;
	sci_data_t     tx_shift;

	logic          rxd_meta, rxd_s;
	logic          rx_busy, rx_smp, rx_stop, rx_ok, rx_ovr, rx_fer;
	logic [3:0]    rx_bit;
	logic [TW-1:0] rx_tcnt;
	sci_data_t     rx_shift;

	assign te     = scr[SCR_TE];
	assign re     = scr[SCR_RE];
	assign wr     = sel && we;
	assign wr_tdr = wr && (offset == REG_TDR);
	assign wr_ssr = wr && (offset == REG_SSR);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cks <= '0;
			brr <= '0;
			scr <= '0;
		end else if (wr) begin
			case (offset)
				REG_SMR: cks <= wdata[1:0];
				REG_BRR: brr <= wdata;
				REG_SCR: scr <= wdata;
				default: ;
			endcase
		end
	end

	// Sample tick every BRR+1 strobes of the selected divider output
	always_comb begin
		case (cks)
			2'd0:    ce_sel = ce.ce4;
			2'd1:    ce_sel = ce.ce16;
			2'd2:    ce_sel = ce.ce64;
			default: ce_sel = ce.ce256;
		endcase
	end

	assign tick = ce_sel && (brr_cnt == '0);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			brr_cnt <= '0;
		else if (ce_sel)
			brr_cnt <= (brr_cnt == '0) ? brr : brr_cnt - 8'd1;
	end

	// Transmitter, bit 0 is start, 1..8 data, 9 stop
	assign tx_adv  = tx_busy && tick && (tx_tcnt == TW'(OVERSAMPLE - 1));
	assign tx_end  = tx_adv && (tx_bit == 4'd9);
	assign tx_load = te && !tdre && (!tx_busy || tx_end);
	assign tx_done = te && tx_end && tdre;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tx_busy <= 1'b0;
			tx_line <= 1'b1;
			tx_bit  <= '0;
			tx_tcnt <= '0;
		end else if (!te) begin
			tx_busy <= 1'b0;
			tx_line <= 1'b1;
		end else if (tx_load) begin
			tx_busy <= 1'b1;
			tx_line <= 1'b0;
			tx_bit  <= '0;
			tx_tcnt <= '0;
		end else if (tx_end) begin
			tx_busy <= 1'b0;
			tx_line <= 1'b1;
		end else if (tx_busy && tick) begin
			tx_tcnt <= tx_tcnt + 1'b1;
			if (tx_adv) begin
				tx_tcnt <= '0;
				tx_bit  <= tx_bit + 4'd1;
				tx_line <= (tx_bit == 4'd8) ? 1'b1 : tx_shift[0];
			end
		end
	end

	// Line idles high while the transmitter is off
	assign txd = tx_line | ~te;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
		end
	end

	// Receiver samples on the 8th tick of each bit
	assign rx_smp  = rx_busy && tick && (rx_tcnt == TW'(OVERSAMPLE / 2 - 1));
	assign rx_stop = rx_smp && (rx_bit == 4'd9);
	assign rx_ok   = rx_stop && !rdrf && rxd_s;
	assign rx_ovr  = rx_stop && rdrf;
	assign rx_fer  = rx_stop && !rdrf && !rxd_s;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rx_busy <= 1'b0;
			rx_bit  <= '0;
			rx_tcnt <= '0;
		end else if (!re) begin
			rx_busy <= 1'b0;
		end else if (!rx_busy) begin
			if (tick && !rxd_s) begin
				rx_busy <= 1'b1;
				rx_bit  <= '0;
				rx_tcnt <= TW'(1);
			end
		end else if (tick) begin
			rx_tcnt <= rx_tcnt + 1'b1;
			if (rx_smp) begin
				rx_bit <= rx_bit + 4'd1;
				// High again at mid start bit means a glitch
				if ((rx_bit == 4'd0 && rxd_s) || rx_bit == 4'd9)
					rx_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_tdr)
			tdr <= wdata;
		if (tx_load)
			tx_shift <= tdr;
		else if (tx_adv)
			tx_shift <= {1'b0, tx_shift[7:1]};
		if (rx_smp && rx_bit >= 4'd1 && rx_bit <= 4'd8)
			rx_shift <= {rxd_s, rx_shift[7:1]};
		if (rx_ok)
			rdr <= rx_shift;
	end

	// Status flags, software can only clear RDRF, ORER and FER
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tdre <= SSR_RESET[SSR_TDRE];
			rdrf <= SSR_RESET[SSR_RDRF];
			orer <= SSR_RESET[SSR_ORER];
			fer  <= SSR_RESET[SSR_FER];
			tend <= SSR_RESET[SSR_TEND];
		end else begin
			if (tx_load)
				tdre <= 1'b1;
			if (tx_done)
				tend <= 1'b1;
			if (wr_tdr) begin
				tdre <= 1'b0;
				tend <= 1'b0;
			end
			if (wr_ssr) begin
				if (!wdata[SSR_RDRF])
					rdrf <= 1'b0;
				if (!wdata[SSR_ORER])
					orer <= 1'b0;
				if (!wdata[SSR_FER])
					fer <= 1'b0;
			end
			if (rx_ok)
				rdrf <= 1'b1;
			if (rx_ovr)
				orer <= 1'b1;
			if (rx_fer)
				fer <= 1'b1;
		end
	end

	always_comb begin
		ssr           = '0;
		ssr[SSR_TDRE] = tdre;
		ssr[SSR_RDRF] = rdrf;
		ssr[SSR_ORER] = orer;
		ssr[SSR_FER]  = fer;
		ssr[SSR_TEND] = tend;
	end

	always_comb begin
		case (offset)
			REG_SMR: rd_byte = {6'd0, cks};
			REG_BRR: rd_byte = brr;
			REG_SCR: rd_byte = scr;
			REG_TDR: rd_byte = tdr;
			REG_SSR: rd_byte = ssr;
			REG_RDR: rd_byte = rdr;
			default: rd_byte = '0;
		endcase
	end

	assign irq.txi = scr[SCR_TIE] & tdre;
	assign irq.rxi = scr[SCR_RIE] & rdrf;
	assign irq.eri = scr[SCR_RIE] & (orer | fer);
	assign irq.tei = scr[SCR_TEIE] & tend;

endmodule

`default_nettype wire

// ==== hdl/sci_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_merge #(
	parameter  int NUM_CH = 2,
	localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
	input  wire logic                            CLK,
	input  wire logic                            RST_N,
	input  wire logic [CH_W-1:0]                 rd_ch,
	input  wire logic                            rd_hit,
	input  wire sci_pkg::sci_data_t [NUM_CH-1:0] ch_rd,
	input  wire sci_pkg::sci_irq_t [NUM_CH-1:0]  ch_irq,
	output sci_pkg::sci_data_t                   rd_data,
	output logic                                 irq,
	output logic [7:0]                           irq_vec
);
	import sci_pkg::*;

	logic [IRQ_CAUSES-1:0] cause [NUM_CH];

	// Out-of-range reads return zero
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			rd_data <= '0;
		else
			rd_data <= rd_hit ? ch_rd[rd_ch] : '0;
	end

	always_comb begin
		for (int c = 0; c < NUM_CH; c++) begin
			cause[c][CAUSE_ERI] = ch_irq[c].eri;
			cause[c][CAUSE_RXI] = ch_irq[c].rxi;
			cause[c][CAUSE_TXI] = ch_irq[c].txi;
			cause[c][CAUSE_TEI] = ch_irq[c].tei;
		end
	end

	// Scan from lowest priority up so the last hit wins
	always_comb begin
		irq     = 1'b0;
		irq_vec = '0;
		for (int c = NUM_CH - 1; c >= 0; c--) begin
			for (int k = IRQ_CAUSES - 1; k >= 0; k--) begin
				if (cause[c][k]) begin
					irq     = 1'b1;
					irq_vec = 8'(c * IRQ_CAUSES + k);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sci_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_top #(
	parameter int NUM_CH = 2
) (
	input  wire logic              CLK,
	input  wire logic              RST_N,
	input  wire sci_pkg::sci_bus_t bus,
	output sci_pkg::sci_data_t     rd_data,
	input  wire logic [NUM_CH-1:0] rxd,
	output wire logic [NUM_CH-1:0] txd,
	output logic                   irq,
	output logic [7:0]             irq_vec
);
	import sci_pkg::*;

	localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

	sci_ce_t                     ce;
	logic [NUM_CH-1:0]           sel;
	logic                        we;
	sci_reg_t                    offset;
	sci_data_t                   wdata;
	logic [CH_W-1:0]             rd_ch;
	logic                        rd_hit;
	wire sci_data_t [NUM_CH-1:0] ch_rd;
	wire sci_irq_t [NUM_CH-1:0]  ch_irq;

	sci_prescaler u_prescaler (
		.CLK   (CLK),
		.RST_N (RST_N),
		.ce    (ce)
	);

	sci_bus_decode #(.NUM_CH(NUM_CH)) u_decode (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.bus    (bus),
		.sel    (sel),
		.we     (we),
		.offset (offset),
		.wdata  (wdata),
		.rd_ch  (rd_ch),
		.rd_hit (rd_hit)
	);

	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		sci_channel u_ch (
			.CLK     (CLK),
			.RST_N   (RST_N),
			.sel     (sel[i]),
			.we      (we),
			.offset  (offset),
			.wdata   (wdata),
			.ce      (ce),
			.rxd     (rxd[i]),
			.txd     (txd[i]),
			.rd_byte (ch_rd[i]),
			.irq     (ch_irq[i])
		);
	end

	sci_merge #(.NUM_CH(NUM_CH)) u_merge (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.rd_ch   (rd_ch),
		.rd_hit  (rd_hit),
		.ch_rd   (ch_rd),
		.ch_irq  (ch_irq),
		.rd_data (rd_data),
		.irq     (irq),
		.irq_vec (irq_vec)
	);

endmodule

`default_nettype wire

// ==== sim/sci_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_chk (
	input wire logic               CLK,
	input wire logic               RST_N,
	input wire logic               tend,
	input wire logic               tdre,
	input wire logic               te,
	input wire logic               tx_line,
	input wire logic               rdrf,
	input wire sci_pkg::sci_data_t rdr
);

	// TEND only rises with an empty data register
	tend_needs_tdre: assert property (@(posedge CLK) disable iff (!RST_N)
		tend |-> tdre)
		else $error("TEND set while TDRE is clear");

	// Transmitter state returns the line to idle once TE is off
	idle_line_high: assert property (@(posedge CLK) disable iff (!RST_N)
		!te |=> tx_line)
		else $error("transmit line low after TE was cleared");

	// Received byte is held until software clears RDRF
	rdr_held: assert property (@(posedge CLK) disable iff (!RST_N)
		(rdrf && $past(rdrf)) |-> $stable(rdr))
		else $error("RDR changed while RDRF stayed set");

endmodule

`default_nettype wire

// ==== sim/sci_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sci_tb;
	import sci_pkg::*;

	localparam int NUM_CH = 2;

	typedef enum {
		K_READ, K_LINE, K_IRQ_IDLE, K_REGRW, K_LOOP, K_OVERRUN, K_FRAMING,
		K_IRQ_TX_RX, K_IRQ_RX, K_IRQ_ERR, K_IRQ_CLEAR
	} kind_t;

	// One row of the stimulus table
	typedef struct {
		string      name;
		kind_t      kind;
		int         ch;
		sci_data_t  brr;
		logic [1:0] cks;
		sci_data_t  data;
		sci_data_t  expected;
	} test_t;

	localparam sci_data_t M_TDRE = sci_data_t'(1 << SSR_TDRE);
	localparam sci_data_t M_RDRF = sci_data_t'(1 << SSR_RDRF);
	localparam sci_data_t M_ORER = sci_data_t'(1 << SSR_ORER);
	localparam sci_data_t M_FER  = sci_data_t'(1 << SSR_FER);
	localparam sci_data_t M_TEND = sci_data_t'(1 << SSR_TEND);
	localparam sci_data_t M_TIE  = sci_data_t'(1 << SCR_TIE);
	localparam sci_data_t M_RIE  = sci_data_t'(1 << SCR_RIE);
	localparam sci_data_t M_TE   = sci_data_t'(1 << SCR_TE);
	localparam sci_data_t M_RE   = sci_data_t'(1 << SCR_RE);

	logic              CLK;
	logic              RST_N;
	sci_bus_t          bus;
	sci_data_t         rd_data;
	logic [NUM_CH-1:0] rxd;
	logic [NUM_CH-1:0] txd;
	logic [NUM_CH-1:0] rxd_drv;
	logic [NUM_CH-1:0] loop;
	logic              irq;
	logic [7:0]        irq_vec;

	test_t tests[$];
	int    errors = 0;
	int    err_before;
	int    npass = 0;
	int    nfail = 0;
	int    cycles = 0;
	int    limit = 0;

	// Per channel loopback or driven line
	assign rxd = (loop & txd) | (~loop & rxd_drv);

	sci_top #(.NUM_CH(NUM_CH)) dut (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.bus     (bus),
		.rd_data (rd_data),
		.rxd     (rxd),
		.txd     (txd),
		.irq     (irq),
		.irq_vec (irq_vec)
	);

	bind sci_channel sci_chk u_chk (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.tend    (tend),
		.tdre    (tdre),
		.te      (te),
		.tx_line (tx_line),
		.rdrf    (rdrf),
		.rdr     (rdr)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// CLK cycles per serial bit
	function automatic int bit_cycles(input sci_data_t brr, input logic [1:0] cks);
		return OVERSAMPLE * (int'(brr) + 1) * (1 << (2 * (int'(cks) + 1)));
	endfunction

	function automatic sci_addr_t reg_addr(input int ch, input sci_reg_t off);
		logic [4:0] ch_f;
		ch_f = 5'(ch);
		return {ch_f, off};
	endfunction

	task automatic add_test(input string name, input kind_t kind, input int ch,
			input sci_data_t brr, input logic [1:0] cks, input sci_data_t data,
			input sci_data_t expected);
		test_t t;
		t.name     = name;
		t.kind     = kind;
		t.ch       = ch;
		t.brr      = brr;
		t.cks      = cks;
		t.data     = data;
		t.expected = expected;
		tests.push_back(t);
	endtask

	task automatic build_table();
		logic [31:0] seed;
		seed = 32'h196d_4ae7;
		for (int c = 0; c < NUM_CH; c++) begin
			add_test($sformatf("rst_ssr%0d", c), K_READ, c, 0, 0, 8'(REG_SSR), 8'h84);
			add_test($sformatf("rst_smr%0d", c), K_READ, c, 0, 0, 8'(REG_SMR), 8'h00);
			add_test($sformatf("rst_brr%0d", c), K_READ, c, 0, 0, 8'(REG_BRR), 8'h00);
			add_test($sformatf("rst_scr%0d", c), K_READ, c, 0, 0, 8'(REG_SCR), 8'h00);
			add_test($sformatf("rst_txd%0d", c), K_LINE, c, 0, 0, 8'h00, 8'h01);
		end
		add_test("rst_irq", K_IRQ_IDLE, 0, 0, 0, 8'h00, 8'h00);
		add_test("rst_oor", K_READ, 31, 0, 0, 8'(REG_SSR), 8'h00);
		add_test("regrw0", K_REGRW, 0, 8'h5A, 2'd2, 8'hB4, 8'hB4);
		add_test("regrw1", K_REGRW, 1, 8'hC3, 2'd1, 8'h64, 8'h64);
		add_test("loop_a", K_LOOP, 0, 8'd0, 2'd0, 8'hA5, 8'hA5);
		add_test("loop_b", K_LOOP, 1, 8'd1, 2'd0, 8'h3C, 8'h3C);
		add_test("loop_c", K_LOOP, 0, 8'd0, 2'd1, 8'h01, 8'h01);
		for (int i = 0; i < 4; i++) begin
			seed = xorshift(seed);
			add_test($sformatf("loop_rnd%0d", i), K_LOOP, i % 2, 8'd0, 2'd0,
				seed[7:0], seed[7:0]);
		end
		add_test("overrun", K_OVERRUN, 0, 8'd0, 2'd0, 8'h96, 8'h96);
		// SSR after a bad stop bit: TDRE, FER, TEND
		add_test("framing", K_FRAMING, 1, 8'd0, 2'd0, 8'h55, 8'h94);
		// Vector is channel * 4 + cause
		add_test("irq_tx0_rx1", K_IRQ_TX_RX, 1, 8'd0, 2'd0, 8'h7E, 8'd2);
		add_test("irq_rx1", K_IRQ_RX, 1, 8'd0, 2'd0, 8'h00, 8'd5);
		add_test("irq_err1", K_IRQ_ERR, 1, 8'd0, 2'd0, 8'h81, 8'd4);
		add_test("irq_clear", K_IRQ_CLEAR, 1, 8'd0, 2'd0, 8'h00, 8'd0);
	endtask

	task automatic bus_write(input int ch, input sci_reg_t off, input sci_data_t d);
		@(posedge CLK);
		bus <= '{req: 1'b1, we: 1'b1, addr: reg_addr(ch, off), wdata: d};
		@(posedge CLK);
		bus <= '0;
	endtask

	task automatic bus_read(input int ch, input sci_reg_t off, output sci_data_t d);
		@(posedge CLK);
		bus <= '{req: 1'b1, we: 1'b0, addr: reg_addr(ch, off), wdata: 8'h00};
		@(posedge CLK);
		bus <= '0;
		// Byte shows one cycle after the access
		@(posedge CLK);
		@(negedge CLK);
		d = rd_data;
	endtask

	task automatic configure(input test_t t, input sci_data_t scr);
		bus_write(t.ch, REG_SMR, {6'd0, t.cks});
		bus_write(t.ch, REG_BRR, t.brr);
		bus_write(t.ch, REG_SCR, scr);
	endtask

	task automatic wait_flag(input int ch, input sci_data_t mask, output sci_data_t v);
		v = 8'h00;
		while ((v & mask) == 8'h00)
			bus_read(ch, REG_SSR, v);
	endtask

	// Start bit, 8 data bits LSB first, stop bit
	task automatic drive_frame(input int ch, input sci_data_t d, input logic stop,
			input int bitc);
		logic [9:0] frame;
		int         n;
		frame = {stop, d, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK);
			rxd_drv[ch] <= frame[i];
			// Short low stop bit so its tail is not taken as a new start bit
			n = (i == 9 && !stop) ? bitc * 3 / 4 : bitc;
			repeat (n - 1) @(posedge CLK);
		end
		@(posedge CLK);
		rxd_drv[ch] <= 1'b1;
		repeat (bitc) @(posedge CLK);
	endtask

	task automatic check_byte(input string name, input sci_data_t exp, input sci_data_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %02h, actual %02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_irq(input string name, input logic exp_irq, input logic [7:0] exp_vec,
			input logic act_irq, input logic [7:0] act_vec);
		if (act_irq !== exp_irq || (exp_irq && act_vec !== exp_vec)) begin
			$display("FAILED %s: expected irq=%b vec=%0d, actual irq=%b vec=%0d",
				name, exp_irq, exp_vec, act_irq, act_vec);
			errors++;
		end
	endtask

	task automatic check_line(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic run_loop(input test_t t);
		sci_data_t v;
		configure(t, M_TE | M_RE);
		bus_write(t.ch, REG_TDR, t.data);
		wait_flag(t.ch, M_RDRF, v);
		check_byte({t.name, ".rdrf"}, M_TDRE | M_RDRF, v);
		wait_flag(t.ch, M_TEND, v);
		check_byte({t.name, ".tend"}, M_TDRE | M_RDRF | M_TEND, v);
		check_line({t.name, ".txd"}, 1'b1, txd[t.ch]);
		bus_read(t.ch, REG_RDR, v);
		check_byte({t.name, ".rdr"}, t.expected, v);
		bus_write(t.ch, REG_SSR, ~M_RDRF);
		bus_read(t.ch, REG_SSR, v);
		check_byte({t.name, ".clr"}, M_TDRE | M_TEND, v);
		bus_write(t.ch, REG_SCR, 8'h00);
	endtask

	task automatic run_test(input test_t t);
		sci_data_t v;
		int        o;
		o = 1 - t.ch;
		case (t.kind)
			K_READ: begin
				bus_read(t.ch, sci_reg_t'(t.data), v);
				check_byte(t.name, t.expected, v);
			end
			K_LINE: begin
				@(negedge CLK);
				check_line(t.name, t.expected[0], txd[t.ch]);
			end
			K_IRQ_IDLE: begin
				@(negedge CLK);
				check_irq(t.name, 1'b0, 8'd0, irq, irq_vec);
			end
			K_REGRW: begin
				configure(t, t.data);
				bus_write(o, REG_SMR, {6'd0, ~t.cks});
				bus_write(o, REG_BRR, ~t.brr);
				bus_write(o, REG_SCR, ~t.data);
				bus_read(t.ch, REG_SMR, v);
				check_byte({t.name, ".smr"}, {6'd0, t.cks}, v);
				bus_read(t.ch, REG_BRR, v);
				check_byte({t.name, ".brr"}, t.brr, v);
				bus_read(t.ch, REG_SCR, v);
				check_byte({t.name, ".scr"}, t.expected, v);
				for (int c = 0; c < NUM_CH; c++) begin
					bus_write(c, REG_SCR, 8'h00);
					bus_write(c, REG_BRR, 8'h00);
					bus_write(c, REG_SMR, 8'h00);
				end
			end
			K_LOOP:
				run_loop(t);
			K_OVERRUN: begin
				configure(t, M_TE | M_RE);
				bus_write(t.ch, REG_TDR, t.data);
				wait_flag(t.ch, M_TEND, v);
				bus_write(t.ch, REG_TDR, ~t.data);
				wait_flag(t.ch, M_TEND, v);
				check_byte({t.name, ".ssr"}, M_TDRE | M_RDRF | M_ORER | M_TEND, v);
				bus_read(t.ch, REG_RDR, v);
				check_byte({t.name, ".rdr"}, t.expected, v);
				bus_write(t.ch, REG_SSR, ~(M_RDRF | M_ORER | M_FER));
				bus_write(t.ch, REG_SCR, 8'h00);
			end
			K_FRAMING: begin
				@(posedge CLK);
				loop[t.ch] <= 1'b0;
				configure(t, M_RE);
				drive_frame(t.ch, t.data, 1'b0, bit_cycles(t.brr, t.cks));
				bus_read(t.ch, REG_SSR, v);
				check_byte({t.name, ".ssr"}, t.expected, v);
				bus_write(t.ch, REG_SSR, ~(M_RDRF | M_ORER | M_FER));
				bus_write(t.ch, REG_SCR, 8'h00);
				@(posedge CLK);
				loop[t.ch] <= 1'b1;
			end
			K_IRQ_TX_RX: begin
				configure(t, M_RIE | M_TE | M_RE);
				bus_write(t.ch, REG_TDR, t.data);
				wait_flag(t.ch, M_RDRF, v);
				bus_write(o, REG_SCR, M_TIE);
				@(negedge CLK);
				check_irq(t.name, 1'b1, t.expected, irq, irq_vec);
			end
			K_IRQ_RX: begin
				bus_write(o, REG_SCR, 8'h00);
				@(negedge CLK);
				check_irq(t.name, 1'b1, t.expected, irq, irq_vec);
			end
			K_IRQ_ERR: begin
				// RDRF still set, so this frame overruns
				bus_write(t.ch, REG_TDR, t.data);
				wait_flag(t.ch, M_TEND, v);
				@(negedge CLK);
				check_irq(t.name, 1'b1, t.expected, irq, irq_vec);
			end
			K_IRQ_CLEAR: begin
				bus_write(t.ch, REG_SSR, ~(M_RDRF | M_ORER | M_FER));
				bus_write(t.ch, REG_SCR, 8'h00);
				@(negedge CLK);
				check_irq(t.name, 1'b0, 8'd0, irq, irq_vec);
			end
			default: begin
				$display("Unknown test kind in row %s", t.name);
				errors++;
			end
		endcase
	endtask

	initial begin
		bus     = '0;
		rxd_drv = '1;
		loop    = '1;
		RST_N   = 1'b0;
		build_table();
		foreach (tests[i])
			limit += 12 * 10 * bit_cycles(tests[i].brr, tests[i].cks);
		limit += 1000;
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;
		@(posedge CLK);
		foreach (tests[i]) begin
			err_before = errors;
			run_test(tests[i]);
			if (errors == err_before) begin
				npass++;
				$display("ok      %s", tests[i].name);
			end else begin
				nfail++;
				$display("failed  %s", tests[i].name);
			end
		end
		$display("Tests: %0d passed, %0d failed", npass, nfail);
		if (nfail == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/sci_pkg.sv
hdl/sci_prescaler.sv
hdl/sci_bus_decode.sv
hdl/sci_channel.sv
hdl/sci_merge.sv
hdl/sci_top.sv
sim/sci_chk.sv
sim/sci_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the SCI testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module sci_tb \
	-Mdir obj_dir \
	-f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vsci_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result is taken from the testbench output
if grep -qxF "All tests passed!" <<< "$output"; then
	exit 0
else
	exit 1
fi
